// ==== hw/chk_settings.svh ====
// ----------------------------
// Packet checker settings
// Bus widths, AR address fields and data generator seed
// ----------------------------

`ifndef CHK_SETTINGS_SVH
`define CHK_SETTINGS_SVH

// Data path
`define CHK_DATA_WIDTH      64
// Generator runs as independent lanes of this width
`define CHK_LANE_WIDTH      16

// AXI address and its fields, msb first
`define CHK_ADDR_WIDTH      32
`define CHK_TGT_ID_WIDTH    4
`define CHK_TGT_ID          4'hA
`define CHK_PAD_WIDTH       4
`define CHK_BYTE_STEP       3
// Whatever is left of the address after target ID, padding and byte offset
`define CHK_INDEX_WIDTH     21

// Read ID and burst length
`define CHK_ID_WIDTH        8
`define CHK_LEN_WIDTH       8

// Seed, no 16-bit lane may be zero or it locks up
`define CHK_RAND_INIT       64'hACE1_5A3C_1234_9E37

// Mismatch retiming depth
`define CHK_ERR_PIPE        3

`endif

// ==== hw/axi_rd_pkg.sv ====
// ----------------------------
// AXI read channel types
// Read ID, burst length and the two views of the AR address
// ----------------------------

`include "chk_settings.svh"

package axi_rd_pkg;

    typedef logic [`CHK_ID_WIDTH-1:0]  axi_id_t;
    typedef logic [`CHK_LEN_WIDTH-1:0] axi_len_t;

    // ----------------------------
    // AR address
    // ----------------------------

    // Field layout, target ID in the top bits
    typedef struct packed {
        logic [`CHK_TGT_ID_WIDTH-1:0] tgt_id;
        logic [`CHK_PAD_WIDTH-1:0]    pad;
        logic [`CHK_INDEX_WIDTH-1:0]  index;
        logic [`CHK_BYTE_STEP-1:0]    byte_off;
    } ar_addr_fields_t;

    // Same word, built by fields and driven flat
    typedef union packed {
        logic [`CHK_ADDR_WIDTH-1:0] flat;
        ar_addr_fields_t            fields;
    } ar_addr_u;

endpackage

// ==== hw/pkt_chk_pkg.sv ====
// ----------------------------
// Packet checker internal types
// Beat word and FSM state encodings
// ----------------------------

`include "chk_settings.svh"

package pkt_chk_pkg;

    // One read beat
    typedef logic [`CHK_DATA_WIDTH-1:0] beat_data_t;

    // AR issue FSM
    typedef enum logic [1:0] {
        AR_IDLE,
        AR_FETCH,
        AR_ISSUE,
        AR_WAIT_READY
    } ar_state_e;

    // Read channel FSM
    typedef enum logic {
        RD_IDLE,
        RD_WAIT_LAST
    } rd_state_e;

endpackage

// ==== hw/rd_beat_if.sv ====
// ----------------------------
// Registered read beats
// Read channel to checker, one cycle behind the AXI handshake
// ----------------------------

`timescale 1ns/1ps

interface rd_beat_if;

    // Beat transferred on the previous cycle
    logic                    beat_valid;
    logic                    beat_last;
    pkt_chk_pkg::beat_data_t beat_data;
    axi_rd_pkg::axi_id_t     beat_id;
    // One cycle pulse as a burst opens
    logic                    read_start;

    modport source (
        output beat_valid, beat_last, beat_data, beat_id, read_start
    );

    modport sink (
        input  beat_valid, beat_last, beat_data, beat_id, read_start
    );

endinterface

// ==== hw/ar_issuer.sv ====
// ----------------------------
// AR issuer
// Fetches a transaction from the upstream queue and issues one
// AXI read address for it with a rolling read ID
// ----------------------------

`timescale 1ns/1ps

`include "chk_settings.svh"

module ar_issuer
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    // Upstream transaction queue
    input  logic                        i_xact_avail,
    input  logic [`CHK_INDEX_WIDTH-1:0] i_xact_addr,
    input  axi_rd_pkg::axi_len_t        i_xact_len,
    output logic                        o_xact_read,
    // High while a burst is still being read
    input  logic                        i_rd_busy,
    // AXI read address channel
    output logic                        o_arvalid,
    input  logic                        i_arready,
    output logic [`CHK_ADDR_WIDTH-1:0]  o_araddr,
    output axi_rd_pkg::axi_len_t        o_arlen,
    output axi_rd_pkg::axi_id_t         o_arid,
    // Pulse per accepted AR with the ID it carried
    output logic                        o_ar_done,
    output axi_rd_pkg::axi_id_t         o_ar_done_id
);

    pkt_chk_pkg::ar_state_e ar_state;
    axi_rd_pkg::ar_addr_u   ar_addr;
    logic                   xact_read_d;

    assign o_araddr = ar_addr.flat;

    // Queue address and length only valid the cycle after the read strobe
    always_ff @(posedge i_clk)
    begin
        if (xact_read_d)
        begin
            ar_addr.fields.tgt_id   <= `CHK_TGT_ID;
            ar_addr.fields.pad      <= '0;
            ar_addr.fields.index    <= i_xact_addr;
            ar_addr.fields.byte_off <= '0;
            o_arlen                 <= i_xact_len;
        end
    end

    // ----------------------------
    // AR FSM
    // ----------------------------
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            ar_state    <= pkt_chk_pkg::AR_IDLE;
            o_xact_read <= 1'b0;
            xact_read_d <= 1'b0;
            o_arvalid   <= 1'b0;
            o_arid      <= '0;
            o_ar_done   <= 1'b0;
        end
        else
        begin
            o_xact_read <= 1'b0;
            o_ar_done   <= 1'b0;
            xact_read_d <= o_xact_read;
            case (ar_state)
                pkt_chk_pkg::AR_IDLE:
                begin
                    if (i_xact_avail)
                    begin
                        o_xact_read <= 1'b1;
                        ar_state    <= pkt_chk_pkg::AR_FETCH;
                    end
                end
                // Queue presents its outputs
                pkt_chk_pkg::AR_FETCH:
                    ar_state <= pkt_chk_pkg::AR_ISSUE;
                // No overlapped reads so hold off while a burst drains
                pkt_chk_pkg::AR_ISSUE:
                begin
                    if (!i_rd_busy)
                    begin
                        o_arvalid <= 1'b1;
                        ar_state  <= pkt_chk_pkg::AR_WAIT_READY;
                    end
                end
                pkt_chk_pkg::AR_WAIT_READY:
                begin
                    if (i_arready)
                    begin
                        o_arvalid    <= 1'b0;
                        o_ar_done    <= 1'b1;
                        o_ar_done_id <= o_arid;
                        o_arid       <= o_arid + 1'b1;
                        ar_state     <= pkt_chk_pkg::AR_IDLE;
                    end
                end
                default:
                    ar_state <= pkt_chk_pkg::AR_IDLE;
            endcase
        end
    end

    // Offered address, length and ID are held until the slave accepts them
    a_arvalid_hold : assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        (o_arvalid && !i_arready) |=>
            (o_arvalid && $stable(o_araddr) && $stable(o_arlen) && $stable(o_arid))
    );

endmodule

// ==== hw/arid_fifo.sv ====
// ----------------------------
// Read ID queue
// Two entry ring of issued IDs, in issue order
// ----------------------------

`timescale 1ns/1ps

module arid_fifo
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    input  logic                i_push,
    input  axi_rd_pkg::axi_id_t i_push_id,
    input  logic                i_pop,
    output axi_rd_pkg::axi_id_t o_head_id
);

    axi_rd_pkg::axi_id_t id_mem [2];
    // Top bit of each pointer is the wrap flag
    logic [1:0]          wr_ptr;
    logic [1:0]          rd_ptr;
    logic                fifo_full;
    logic                fifo_empty;

    assign fifo_empty = (wr_ptr == rd_ptr);
    assign fifo_full  = (wr_ptr == {~rd_ptr[1], rd_ptr[0]});
    assign o_head_id  = id_mem[rd_ptr[0]];

    always_ff @(posedge i_clk)
    begin
        if (i_push)
            id_mem[wr_ptr[0]] <= i_push_id;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end
        else
        begin
            if (i_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (i_pop)
                rd_ptr <= rd_ptr + 1'b1;
        end
    end

    // AR issue and last-beat check must stay in step
    a_no_overflow : assert property (
        @(posedge i_clk) disable iff (!i_reset_n) !(i_push && fifo_full)
    );
    a_no_underflow : assert property (
        @(posedge i_clk) disable iff (!i_reset_n) !(i_pop && fifo_empty)
    );

endmodule

// ==== hw/rd_channel.sv ====
// ----------------------------
// Read channel
// rready control per burst and registering of transferred beats
// ----------------------------

`timescale 1ns/1ps

module rd_channel
(
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    // AR accepted on the previous cycle
    input  logic                    i_ar_done,
    // AXI read data channel
    input  logic                    i_rvalid,
    input  pkt_chk_pkg::beat_data_t i_rdata,
    input  logic                    i_rlast,
    input  axi_rd_pkg::axi_id_t     i_rid,
    output logic                    o_rready,
    // Back to the AR issuer
    output logic                    o_rd_busy,
    rd_beat_if.source               beat
);

    pkt_chk_pkg::rd_state_e rd_state;
    logic                   rd_xfer;

    assign rd_xfer   = i_rvalid && o_rready;
    assign o_rd_busy = o_rready;

    // ----------------------------
    // Ready FSM
    // ----------------------------
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            rd_state        <= pkt_chk_pkg::RD_IDLE;
            o_rready        <= 1'b0;
            beat.read_start <= 1'b0;
        end
        else
        begin
            beat.read_start <= 1'b0;
            case (rd_state)
                pkt_chk_pkg::RD_IDLE:
                begin
                    if (i_ar_done)
                    begin
                        o_rready        <= 1'b1;
                        beat.read_start <= 1'b1;
                        rd_state        <= pkt_chk_pkg::RD_WAIT_LAST;
                    end
                end
                // Gaps in rvalid just stretch this state
                pkt_chk_pkg::RD_WAIT_LAST:
                begin
                    if (i_rvalid && i_rlast)
                    begin
                        o_rready <= 1'b0;
                        rd_state <= pkt_chk_pkg::RD_IDLE;
                    end
                end
                default:
                    rd_state <= pkt_chk_pkg::RD_IDLE;
            endcase
        end
    end

    // Beat register stage
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            beat.beat_valid <= 1'b0;
        else
            beat.beat_valid <= rd_xfer;
    end

    always_ff @(posedge i_clk)
    begin
        if (rd_xfer)
        begin
            beat.beat_last <= i_rlast;
            beat.beat_data <= i_rdata;
            beat.beat_id   <= i_rid;
        end
    end

    // A new burst can only open once the previous one has closed
    a_open_after_close : assert property (
        @(posedge i_clk) disable iff (!i_reset_n)
        i_ar_done |-> (rd_state == pkt_chk_pkg::RD_IDLE)
    );

endmodule

// ==== hw/data_lfsr.sv ====
// ----------------------------
// Expected data generator
// Parallel 16-bit Fibonacci LFSR lanes, one step per advance
// ----------------------------

`timescale 1ns/1ps

`include "chk_settings.svh"

module data_lfsr
(
    input  logic                    i_clk,
    input  logic                    i_reset_n,
    input  logic                    i_advance,
    output pkt_chk_pkg::beat_data_t o_data
);

    localparam int LANE_W    = `CHK_LANE_WIDTH;
    localparam int NUM_LANES = `CHK_DATA_WIDTH / `CHK_LANE_WIDTH;
    localparam logic [`CHK_DATA_WIDTH-1:0] RAND_INIT = `CHK_RAND_INIT;

    for (genvar lane = 0; lane < NUM_LANES; lane++)
    begin : g_lane
        logic [LANE_W-1:0] lfsr;
        logic              feedback;

        // Taps 16, 14, 13, 11 give the maximal length sequence
        assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

        always_ff @(posedge i_clk)
        begin
            if (!i_reset_n)
                lfsr <= RAND_INIT[lane*LANE_W +: LANE_W];
            else if (i_advance)
                lfsr <= {lfsr[LANE_W-2:0], feedback};
        end

        assign o_data[lane*LANE_W +: LANE_W] = lfsr;
    end

endmodule

// ==== hw/pkt_checker.sv ====
// ----------------------------
// Packet checker
// Compares beats with regenerated data, checks the burst read ID
// and reports packet done and a sticky error
// ----------------------------

`timescale 1ns/1ps

`include "chk_settings.svh"

module pkt_checker
(
    input  logic                i_clk,
    input  logic                i_reset_n,
    rd_beat_if.sink             beat,
    // Oldest outstanding read ID
    input  axi_rd_pkg::axi_id_t i_head_id,
    output logic                o_id_pop,
    output logic                o_pkt_compared,
    output logic                o_pkt_error
);

    pkt_chk_pkg::beat_data_t  exp_data;
    logic                     lfsr_advance;
    logic                     last_beat;
    logic                     beat_valid_d;
    logic                     beat_valid_2d;
    logic                     last_beat_d;
    logic                     data_match;
    logic                     data_match_d;
    logic                     data_error;
    logic [`CHK_ERR_PIPE-1:0] data_error_pipe;
    logic                     id_error;

    assign last_beat = beat.beat_valid && beat.beat_last;
    assign o_id_pop  = last_beat;

    // Step at burst start, then after every beat but the last
    // so the next beat always sees a fresh value
    assign lfsr_advance = beat.read_start || (beat.beat_valid && !beat.beat_last);

    data_lfsr data_lfsr_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_advance (lfsr_advance),
        .o_data    (exp_data)
    );

    // ----------------------------
    // Data compare
    // ----------------------------
    // Case equality so an X beat counts as a mismatch
    // Match is registered twice to leave room for retiming
    always_ff @(posedge i_clk)
    begin
        data_match   <= (exp_data === beat.beat_data);
        data_match_d <= data_match;
    end

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            beat_valid_d    <= 1'b0;
            beat_valid_2d   <= 1'b0;
            last_beat_d     <= 1'b0;
            data_error      <= 1'b0;
            data_error_pipe <= '0;
            id_error        <= 1'b0;
            o_pkt_compared  <= 1'b0;
            o_pkt_error     <= 1'b0;
        end
        else
        begin
            // Beat valid follows the match through its two stages
            beat_valid_d    <= beat.beat_valid;
            beat_valid_2d   <= beat_valid_d;
            data_error      <= beat_valid_2d && !data_match_d;
            data_error_pipe <= {data_error_pipe[`CHK_ERR_PIPE-2:0], data_error};

            // ID check against the queue head on the closing beat
            id_error <= last_beat && (beat.beat_id != i_head_id);

            last_beat_d    <= last_beat;
            o_pkt_compared <= last_beat_d;

            // Sticky until reset
            if (data_error_pipe[`CHK_ERR_PIPE-1] || id_error)
                o_pkt_error <= 1'b1;
        end
    end

endmodule

// ==== hw/axi_pkt_chk_top.sv ====
// ----------------------------
// AXI packet checker top
// Read side checker for one network access point
// ----------------------------

`timescale 1ns/1ps

`include "chk_settings.svh"

module axi_pkt_chk_top
(
    input  logic                        i_clk,
    input  logic                        i_reset_n,
    // Transaction queue
    input  logic                        i_xact_avail,
    input  logic [`CHK_INDEX_WIDTH-1:0] i_xact_addr,
    input  logic [`CHK_LEN_WIDTH-1:0]   i_xact_len,
    output logic                        o_xact_read,
    // AXI read address channel
    output logic                        o_arvalid,
    input  logic                        i_arready,
    output logic [`CHK_ADDR_WIDTH-1:0]  o_araddr,
    output logic [`CHK_LEN_WIDTH-1:0]   o_arlen,
    output logic [`CHK_ID_WIDTH-1:0]    o_arid,
    // AXI read data channel
    input  logic                        i_rvalid,
    output logic                        o_rready,
    input  logic [`CHK_DATA_WIDTH-1:0]  i_rdata,
    input  logic                        i_rlast,
    input  logic [`CHK_ID_WIDTH-1:0]    i_rid,
    // Results
    output logic                        o_pkt_compared,
    output logic                        o_pkt_error
);

    logic                ar_done;
    axi_rd_pkg::axi_id_t ar_done_id;
    logic                rd_busy;
    logic                id_pop;
    axi_rd_pkg::axi_id_t head_id;

    rd_beat_if beat_if ();

    ar_issuer ar_issuer_inst (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_xact_avail (i_xact_avail),
        .i_xact_addr  (i_xact_addr),
        .i_xact_len   (i_xact_len),
        .o_xact_read  (o_xact_read),
        .i_rd_busy    (rd_busy),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .o_araddr     (o_araddr),
        .o_arlen      (o_arlen),
        .o_arid       (o_arid),
        .o_ar_done    (ar_done),
        .o_ar_done_id (ar_done_id)
    );

    // IDs wait here until their burst closes
    arid_fifo arid_fifo_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_push    (ar_done),
        .i_push_id (ar_done_id),
        .i_pop     (id_pop),
        .o_head_id (head_id)
    );

    rd_channel rd_channel_inst (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_ar_done (ar_done),
        .i_rvalid  (i_rvalid),
        .i_rdata   (i_rdata),
        .i_rlast   (i_rlast),
        .i_rid     (i_rid),
        .o_rready  (o_rready),
        .o_rd_busy (rd_busy),
        .beat      (beat_if.source)
    );

    pkt_checker pkt_checker_inst (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .beat           (beat_if.sink),
        .i_head_id      (head_id),
        .o_id_pop       (id_pop),
        .o_pkt_compared (o_pkt_compared),
        .o_pkt_error    (o_pkt_error)
    );

endmodule

// ==== testbench/tb_axi_pkt_chk.sv ====
// ------------------------------
// Packet checker testbench
// AXI slave model and reference LFSR run a table of transactions
// ------------------------------

`timescale 1ns/1ps

`include "chk_settings.svh"

module tb_axi_pkt_chk;

    // One transaction with its expected outcome
    typedef struct packed {
        logic [`CHK_INDEX_WIDTH-1:0] index;
        axi_rd_pkg::axi_len_t        len;
        logic                        reset_before;
        // Beat number to corrupt or -1 for none
        int                          corrupt_beat;
        logic                        corrupt_id;
        // Error level once the packet is done
        logic                        exp_err;
    } xact_row_t;

    localparam int NUM_ROWS = 11;

    // DUT inputs
    logic                        i_clk = 1'b0;
    logic                        i_reset_n;
    logic                        i_xact_avail;
    logic [`CHK_INDEX_WIDTH-1:0] i_xact_addr;
    axi_rd_pkg::axi_len_t        i_xact_len;
    logic                        i_arready;
    logic                        i_rvalid;
    pkt_chk_pkg::beat_data_t     i_rdata;
    logic                        i_rlast;
    axi_rd_pkg::axi_id_t         i_rid;
    // DUT outputs
    logic                        o_xact_read;
    logic                        o_arvalid;
    logic [`CHK_ADDR_WIDTH-1:0]  o_araddr;
    axi_rd_pkg::axi_len_t        o_arlen;
    axi_rd_pkg::axi_id_t         o_arid;
    logic                        o_rready;
    logic                        o_pkt_compared;
    logic                        o_pkt_error;

    xact_row_t               table_rows [NUM_ROWS];
    bit                      table_ready = 1'b0;
    int                      cycle_cnt = 0;
    // Cycles where the done pulse is due and where the error must be up
    int                      cmp_due = -1;
    int                      err_due = -1;
    pkt_chk_pkg::beat_data_t ref_data;
    axi_rd_pkg::axi_id_t     exp_id;
    axi_rd_pkg::axi_id_t     burst_id;
    bit                      next_presented;
    int unsigned             seed_val;

    axi_pkt_chk_top axi_pkt_chk_top_inst (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_xact_avail   (i_xact_avail),
        .i_xact_addr    (i_xact_addr),
        .i_xact_len     (i_xact_len),
        .o_xact_read    (o_xact_read),
        .o_arvalid      (o_arvalid),
        .i_arready      (i_arready),
        .o_araddr       (o_araddr),
        .o_arlen        (o_arlen),
        .o_arid         (o_arid),
        .i_rvalid       (i_rvalid),
        .o_rready       (o_rready),
        .i_rdata        (i_rdata),
        .i_rlast        (i_rlast),
        .i_rid          (i_rid),
        .o_pkt_compared (o_pkt_compared),
        .o_pkt_error    (o_pkt_error)
    );

    always #50 i_clk = ~i_clk;

    always @(posedge i_clk)
        cycle_cnt <= cycle_cnt + 1;

    // ------------------------------
    // Failure and compare helpers
    // ------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_id(input string name, input axi_rd_pkg::axi_id_t got,
                            input axi_rd_pkg::axi_id_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_len(input string name, input axi_rd_pkg::axi_len_t got,
                             input axi_rd_pkg::axi_len_t exp);
        if (got !== exp)
            stop_with_failure($sformatf("error %s got %h expected %h", name, got, exp));
    endtask

    // Address decoded field by field as tgt_id pad index byte_off
    task automatic check_addr(input axi_rd_pkg::ar_addr_u got,
                              input logic [`CHK_INDEX_WIDTH-1:0] exp_index);
        if (got.fields.tgt_id !== `CHK_TGT_ID)
            stop_with_failure($sformatf("error o_araddr.tgt_id got %h expected %h",
                                        got.fields.tgt_id, `CHK_TGT_ID));
        if (got.fields.pad !== '0)
            stop_with_failure($sformatf("error o_araddr.pad got %h expected 0",
                                        got.fields.pad));
        if (got.fields.index !== exp_index)
            stop_with_failure($sformatf("error o_araddr.index got %h expected %h",
                                        got.fields.index, exp_index));
        if (got.fields.byte_off !== '0)
            stop_with_failure($sformatf("error o_araddr.byte_off got %h expected 0",
                                        got.fields.byte_off));
    endtask

    // Reference generator where each 16-bit lane shifts left with taps 15 13 12 10
    function automatic pkt_chk_pkg::beat_data_t lfsr_step(input pkt_chk_pkg::beat_data_t cur);
        pkt_chk_pkg::beat_data_t nxt;
        logic [`CHK_LANE_WIDTH-1:0] lane;
        for (int l = 0; l < `CHK_DATA_WIDTH / `CHK_LANE_WIDTH; l++)
        begin
            lane = cur[l*`CHK_LANE_WIDTH +: `CHK_LANE_WIDTH];
            nxt[l*`CHK_LANE_WIDTH +: `CHK_LANE_WIDTH] =
                {lane[14:0], lane[15] ^ lane[13] ^ lane[12] ^ lane[10]};
        end
        return nxt;
    endfunction

    // Earliest deadline wins since the error is sticky
    task automatic note_error_deadline(input int due);
        if (err_due < 0 || due < err_due)
            err_due = due;
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    task automatic load_table();
        //                index       len    rst   beat  bad id exp err
        table_rows[0]  = '{21'h00010, 8'd0,  1'b0, -1,   1'b0,  1'b0};
        table_rows[1]  = '{21'h1ABCD, 8'd3,  1'b0, -1,   1'b0,  1'b0};
        table_rows[2]  = '{21'h0F00F, 8'd15, 1'b0, -1,   1'b0,  1'b0};
        table_rows[3]  = '{21'h12345, 8'd7,  1'b0, -1,   1'b0,  1'b0};
        table_rows[4]  = '{21'h1FFFF, 8'd20, 1'b0, -1,   1'b0,  1'b0};
        // Bad data then the error stays set over a clean packet
        table_rows[5]  = '{21'h00200, 8'd4,  1'b0, 2,    1'b0,  1'b1};
        table_rows[6]  = '{21'h00300, 8'd2,  1'b0, -1,   1'b0,  1'b1};
        table_rows[7]  = '{21'h00400, 8'd5,  1'b1, -1,   1'b0,  1'b0};
        table_rows[8]  = '{21'h00500, 8'd3,  1'b0, -1,   1'b1,  1'b1};
        table_rows[9]  = '{21'h1CAFE, 8'd6,  1'b1, -1,   1'b0,  1'b0};
        table_rows[10] = '{21'h00777, 8'd0,  1'b0, 0,    1'b0,  1'b1};
    endtask

    task automatic next_cycle();
        @(posedge i_clk);
        #1;
    endtask

    task automatic apply_reset();
        i_reset_n    = 1'b0;
        i_xact_avail = 1'b0;
        i_arready    = 1'b0;
        i_rvalid     = 1'b0;
        i_rlast      = 1'b0;
        ref_data     = `CHK_RAND_INIT;
        exp_id       = '0;
        err_due      = -1;
        cmp_due      = -1;
        repeat (5) next_cycle();
        i_reset_n = 1'b1;
        check_bit("o_xact_read", o_xact_read, 1'b0);
        check_bit("o_arvalid", o_arvalid, 1'b0);
        check_bit("o_rready", o_rready, 1'b0);
        check_bit("o_pkt_compared", o_pkt_compared, 1'b0);
        check_bit("o_pkt_error", o_pkt_error, 1'b0);
    endtask

    // Queue side with address and length only on the cycle after the read strobe
    task automatic present_xact(input int r);
        i_xact_avail = 1'b1;
        next_cycle();
        while (o_xact_read !== 1'b1)
            next_cycle();
        i_xact_avail = 1'b0;
        next_cycle();
        check_bit("o_xact_read", o_xact_read, 1'b0);
        i_xact_addr  = table_rows[r].index;
        i_xact_len   = table_rows[r].len;
        next_cycle();
    endtask

    task automatic serve_ar(input int r);
        int delay;
        delay = $urandom % 4;
        while (o_arvalid !== 1'b1)
            next_cycle();
        check_addr(o_araddr, table_rows[r].index);
        check_len("o_arlen", o_arlen, table_rows[r].len);
        check_id("o_arid", o_arid, exp_id);
        burst_id = o_arid;
        // Slave stalls while arvalid must hold
        repeat (delay)
        begin
            next_cycle();
            check_bit("o_arvalid", o_arvalid, 1'b1);
        end
        i_arready = 1'b1;
        next_cycle();
        i_arready = 1'b0;
        check_bit("o_arvalid", o_arvalid, 1'b0);
        check_bit("o_rready", o_rready, 1'b0);
        exp_id = axi_rd_pkg::axi_id_t'(exp_id + 1);
    endtask

    task automatic serve_burst(input int r);
        int nbeats;
        int gap;
        pkt_chk_pkg::beat_data_t data;
        nbeats = int'(table_rows[r].len) + 1;
        // rready two cycles after the accepting arready
        next_cycle();
        for (int b = 0; b < nbeats; b++)
        begin
            gap = $urandom % 3;
            repeat (gap) next_cycle();
            check_bit("o_rready", o_rready, 1'b1);
            ref_data = lfsr_step(ref_data);
            data     = ref_data;
            if (b == table_rows[r].corrupt_beat)
            begin
                data = data ^ 64'h0000_0000_0000_0100;
                note_error_deadline(cycle_cnt + 8);
            end
            i_rvalid = 1'b1;
            i_rdata  = data;
            i_rlast  = (b == nbeats - 1);
            i_rid    = burst_id;
            if (b == nbeats - 1)
            begin
                cmp_due = cycle_cnt + 3;
                if (table_rows[r].corrupt_id)
                begin
                    i_rid = burst_id ^ 8'h01;
                    note_error_deadline(cycle_cnt + 3);
                end
            end
            next_cycle();
            i_rvalid = 1'b0;
            i_rlast  = 1'b0;
        end
        check_bit("o_rready", o_rready, 1'b0);
    endtask

    // ------------------------------
    // Per cycle monitor sampled mid cycle
    // ------------------------------
    always @(negedge i_clk)
    begin
        if (i_reset_n)
        begin
            if (o_arvalid && o_rready)
                stop_with_failure("a new AR was offered while rready was still high");
            check_bit("o_pkt_compared", o_pkt_compared, logic'(cycle_cnt == cmp_due));
            if (err_due < 0)
                check_bit("o_pkt_error", o_pkt_error, 1'b0);
            else if (cycle_cnt >= err_due)
                check_bit("o_pkt_error", o_pkt_error, 1'b1);
        end
    end

    // Watchdog scaled by the total number of beats
    initial
    begin
        int total_beats;
        int limit;
        wait (table_ready);
        total_beats = 0;
        for (int r = 0; r < NUM_ROWS; r++)
            total_beats += int'(table_rows[r].len) + 1;
        limit = total_beats * 40 + 200;
        repeat (limit) @(posedge i_clk);
        stop_with_failure("watchdog timeout, the DUT stopped making progress");
    end

    initial
    begin
        i_reset_n      = 1'b0;
        i_xact_avail   = 1'b0;
        i_xact_addr    = '0;
        i_xact_len     = '0;
        i_arready      = 1'b0;
        i_rvalid       = 1'b0;
        i_rdata        = '0;
        i_rlast        = 1'b0;
        i_rid          = '0;
        next_presented = 1'b0;
        seed_val       = $urandom(32'h59fc2779);
        load_table();
        table_ready = 1'b1;
        apply_reset();

        for (int r = 0; r < NUM_ROWS; r++)
        begin
            if (!next_presented)
            begin
                if (table_rows[r].reset_before)
                    apply_reset();
                present_xact(r);
            end
            serve_ar(r);
            next_presented = 1'b0;
            if (r + 1 < NUM_ROWS)
                next_presented = !table_rows[r + 1].reset_before;
            // Next transaction queues up while this burst drains
            fork
                serve_burst(r);
                begin
                    if (next_presented)
                        present_xact(r + 1);
                end
            join
            while (cycle_cnt <= cmp_due || cycle_cnt <= err_due)
                next_cycle();
            check_bit("o_pkt_error", o_pkt_error, table_rows[r].exp_err);
        end

        $display("All checks passed");
        $finish;
    end

endmodule

// ==== axi_pkt_chk.f ====
+incdir+hw
hw/axi_rd_pkg.sv
hw/pkt_chk_pkg.sv
hw/rd_beat_if.sv
hw/ar_issuer.sv
hw/arid_fifo.sv
hw/rd_channel.sv
hw/data_lfsr.sv
hw/pkt_checker.sv
hw/axi_pkt_chk_top.sv
testbench/tb_axi_pkt_chk.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the AXI packet checker testbench with Verilator
# Exit status is nonzero when the build fails or the testbench stops on a $fatal

cd "$(dirname "$0")" || exit 1

OBJ_DIR=obj_dir
TOP=tb_axi_pkt_chk

verilator --binary --timing --assert -Mdir "$OBJ_DIR" --top-module "$TOP" -f axi_pkt_chk.f
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

"./$OBJ_DIR/V$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished"
exit 0
